/* design/chip_pkg.sv */
// Shared pad counts, pad indices and JTAG TAP constants for the board wrapper
// Referenced by scoped names from the RTL and the testbench

package chip_pkg;

  ////////////////////////////////////////////////////////////////////
  // Pad counts
  ////////////////////////////////////////////////////////////////////

  localparam int NumMio  = 8;                   // Muxed GPIO pads
  localparam int NumDio  = 5;                   // Dedicated pads incl. strap
  localparam int NumPads = NumMio + NumDio;
  localparam int NumGpio = NumMio + NumDio - 1; // Strap is not owned by the core

  // Dedicated pad indices, offset by NumMio in the full pad vector
  localparam int DioTck    = 0;
  localparam int DioTms    = 1;
  localparam int DioTdi    = 2;
  localparam int DioTdo    = 3;
  localparam int DioJtagEn = 4;

  ////////////////////////////////////////////////////////////////////
  // TAP instructions and data registers
  ////////////////////////////////////////////////////////////////////

  localparam int IrWidth = 4;

  localparam logic [IrWidth-1:0] InstrIdcode = 4'h1;
  localparam logic [IrWidth-1:0] InstrGpio   = 4'h8;
  localparam logic [IrWidth-1:0] InstrBypass = 4'hF; // Unknown codes also bypass

  localparam logic [31:0] IdCode = 32'h0B41_70C1; // LSB must be 1

  // Fields from LSB: out, oe, invert, then one mirror bit
  localparam int GpioDrWidth = 3 * NumGpio + 1;

endpackage

/* design/pad_ring.sv */
// Board pad ring model with split in/out/oe bits instead of tristates
// Synchronizes pad inputs and applies per-pad invert and connect mask

`timescale 1ns/100ps

module pad_ring #(
  // Unconnected pads read 0 and never drive
  parameter logic [chip_pkg::NumPads-1:0] ConnectMask = '1
) (
  input  logic                         clk,
  input  logic                         rst_i,
  // Pad side
  input  logic [chip_pkg::NumPads-1:0] pad_in_i,
  output logic [chip_pkg::NumPads-1:0] pad_out_o,
  output logic [chip_pkg::NumPads-1:0] pad_oe_o,
  // Core side
  output logic [chip_pkg::NumPads-1:0] in_o,
  input  logic [chip_pkg::NumPads-1:0] out_i,
  input  logic [chip_pkg::NumPads-1:0] oe_i,
  input  logic [chip_pkg::NumPads-1:0] invert_i
);

  logic [chip_pkg::NumPads-1:0] sync_q1;
  logic [chip_pkg::NumPads-1:0] sync_q2;
  logic [chip_pkg::NumPads-1:0] in_attr;

  ////////////////////////////////////////////////////////////////////
  // Input path
  ////////////////////////////////////////////////////////////////////

  // Invert ahead of the first flop, so the core side never sees a
  // combinational path from its own attribute back into its inputs
  assign in_attr = (pad_in_i ^ invert_i) & ConnectMask;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= in_attr;
      sync_q2 <= sync_q1;  // Second stage for metastability
    end
  end

  assign in_o = sync_q2;  // Two cycles from pad to core

  ////////////////////////////////////////////////////////////////////
  // Output path
  ////////////////////////////////////////////////////////////////////

  assign pad_out_o = (out_i ^ invert_i) & ConnectMask;
  assign pad_oe_o  = oe_i & ConnectMask;  // Masked pads stay high-Z

endmodule

/* design/jtag_overlay_mux.sv */
// JTAG overlay between the pad ring and the core
// Strap pad hands the four dedicated JTAG pads to the TAP, core sees tie-offs

`timescale 1ns/100ps

module jtag_overlay_mux #(
  parameter logic [chip_pkg::NumPads-1:0] TieOffValues   = '0,
  parameter bit                           JtagEnPolarity = 1'b1
) (
  // Pad ring side
  input  logic [chip_pkg::NumPads-1:0] in_padring_i,
  output logic [chip_pkg::NumPads-1:0] out_padring_o,
  output logic [chip_pkg::NumPads-1:0] oe_padring_o,
  // Core side
  output logic [chip_pkg::NumGpio-1:0] in_core_o,
  input  logic [chip_pkg::NumGpio-1:0] out_core_i,
  input  logic [chip_pkg::NumGpio-1:0] oe_core_i,
  // TAP side
  output logic                         jtag_tck_o,
  output logic                         jtag_tms_o,
  output logic                         jtag_tdi_o,
  input  logic                         jtag_tdo_i,
  output logic                         jtag_active_o
);

  // Positions in the full pad vector; DIO 3..0 share them on the core side
  localparam int TckIdx  = chip_pkg::NumMio + chip_pkg::DioTck;
  localparam int TmsIdx  = chip_pkg::NumMio + chip_pkg::DioTms;
  localparam int TdiIdx  = chip_pkg::NumMio + chip_pkg::DioTdi;
  localparam int TdoIdx  = chip_pkg::NumMio + chip_pkg::DioTdo;
  localparam int StrapIdx = chip_pkg::NumMio + chip_pkg::DioJtagEn;

  assign jtag_active_o = (in_padring_i[StrapIdx] == JtagEnPolarity);

  always_comb begin
    // Default is straight pass-through, strap pad input only
    in_core_o     = in_padring_i[chip_pkg::NumGpio-1:0];
    out_padring_o = {1'b0, out_core_i};
    oe_padring_o  = {1'b0, oe_core_i};
    jtag_tck_o    = 1'b0;
    jtag_tms_o    = 1'b0;
    jtag_tdi_o    = 1'b0;

    if (jtag_active_o) begin
      jtag_tck_o = in_padring_i[TckIdx];
      jtag_tms_o = in_padring_i[TmsIdx];
      jtag_tdi_o = in_padring_i[TdiIdx];

      // Core sees fixed values on the borrowed pads
      in_core_o[TckIdx] = TieOffValues[TckIdx];
      in_core_o[TmsIdx] = TieOffValues[TmsIdx];
      in_core_o[TdiIdx] = TieOffValues[TdiIdx];
      in_core_o[TdoIdx] = TieOffValues[TdoIdx];

      out_padring_o[TckIdx] = 1'b0;
      out_padring_o[TmsIdx] = 1'b0;
      out_padring_o[TdiIdx] = 1'b0;
      oe_padring_o[TckIdx]  = 1'b0;  // JTAG inputs
      oe_padring_o[TmsIdx]  = 1'b0;
      oe_padring_o[TdiIdx]  = 1'b0;

      out_padring_o[TdoIdx] = jtag_tdo_i;
      oe_padring_o[TdoIdx]  = 1'b1;
    end
  end

endmodule

/* design/jtag_tap.sv */
// JTAG TAP controller running in the clk domain on an oversampled TCK
// Supports IDCODE, BYPASS and the GPIO data register

`timescale 1ns/100ps

module jtag_tap (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             jtag_active_i,
  input  logic                             tck_i,       // Already synchronized
  input  logic                             tms_i,
  input  logic                             tdi_i,
  output logic                             tdo_o,
  input  logic [chip_pkg::GpioDrWidth-1:0] gpio_capture_i,
  output logic [chip_pkg::GpioDrWidth-1:0] gpio_update_o,
  output logic                             gpio_update_valid_o
);

  localparam int IdWidth = $bits(chip_pkg::IdCode);

  typedef enum logic [3:0] {
    TestLogicReset, RunTestIdle,
    SelectDrScan, CaptureDr, ShiftDr, Exit1Dr, PauseDr, Exit2Dr, UpdateDr,
    SelectIrScan, CaptureIr, ShiftIr, Exit1Ir, PauseIr, Exit2Ir, UpdateIr
  } tap_state_e;

  tap_state_e                       state_q, state_d;
  logic                             tap_rst;
  logic                             tck_q;
  logic                             tck_rise;
  logic                             tck_fall;
  logic [chip_pkg::IrWidth-1:0]     ir_q;
  logic [chip_pkg::IrWidth-1:0]     ir_shift_q;
  logic [chip_pkg::GpioDrWidth-1:0] dr_shift_q;

  assign tap_rst = rst_i | ~jtag_active_i;  // Idle TAP while pads belong to GPIO

  ////////////////////////////////////////////////////////////////////
  // TCK edge detect and TAP state machine
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tap_rst) tck_q <= 1'b0;
    else         tck_q <= tck_i;
  end

  assign tck_rise = tck_i & ~tck_q;
  assign tck_fall = ~tck_i & tck_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      TestLogicReset: state_d = tms_i ? TestLogicReset : RunTestIdle;
      RunTestIdle:    state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectDrScan:   state_d = tms_i ? SelectIrScan   : CaptureDr;
      CaptureDr:      state_d = tms_i ? Exit1Dr        : ShiftDr;
      ShiftDr:        state_d = tms_i ? Exit1Dr        : ShiftDr;
      Exit1Dr:        state_d = tms_i ? UpdateDr       : PauseDr;
      PauseDr:        state_d = tms_i ? Exit2Dr        : PauseDr;
      Exit2Dr:        state_d = tms_i ? UpdateDr       : ShiftDr;
      UpdateDr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectIrScan:   state_d = tms_i ? TestLogicReset : CaptureIr;
      CaptureIr:      state_d = tms_i ? Exit1Ir        : ShiftIr;
      ShiftIr:        state_d = tms_i ? Exit1Ir        : ShiftIr;
      Exit1Ir:        state_d = tms_i ? UpdateIr       : PauseIr;
      PauseIr:        state_d = tms_i ? Exit2Ir        : PauseIr;
      Exit2Ir:        state_d = tms_i ? UpdateIr       : ShiftIr;
      UpdateIr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
      default:        state_d = TestLogicReset;
    endcase
  end

  always_ff @(posedge clk) begin
    if (tap_rst)       state_q <= TestLogicReset;
    else if (tck_rise) state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////////////
  // Instruction and data registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tap_rst || state_q == TestLogicReset) begin
      ir_q <= chip_pkg::InstrIdcode;
    end else if (tck_fall && state_q == UpdateIr) begin
      ir_q <= ir_shift_q;
    end
  end

  always_ff @(posedge clk) begin
    if (tck_rise && state_q == CaptureIr) begin
      ir_shift_q <= chip_pkg::IrWidth'(1);  // Fixed 01 pattern in the LSBs
    end else if (tck_rise && state_q == ShiftIr) begin
      ir_shift_q <= {tdi_i, ir_shift_q[chip_pkg::IrWidth-1:1]};
    end
  end

  // One shift register serves all three data registers, length set by IR
  always_ff @(posedge clk) begin
    if (tck_rise && state_q == CaptureDr) begin
      case (ir_q)
        chip_pkg::InstrIdcode: dr_shift_q <= chip_pkg::GpioDrWidth'(chip_pkg::IdCode);
        chip_pkg::InstrGpio:   dr_shift_q <= gpio_capture_i;
        default:               dr_shift_q <= '0;
      endcase
    end else if (tck_rise && state_q == ShiftDr) begin
      case (ir_q)
        chip_pkg::InstrIdcode: dr_shift_q[IdWidth-1:0] <= {tdi_i, dr_shift_q[IdWidth-1:1]};
        chip_pkg::InstrGpio:   dr_shift_q <= {tdi_i, dr_shift_q[chip_pkg::GpioDrWidth-1:1]};
        default:               dr_shift_q[0] <= tdi_i;  // 1-bit bypass
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // TDO and GPIO update
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tap_rst) begin
      tdo_o <= 1'b0;
    end else if (tck_fall) begin
      if (state_q == ShiftIr)      tdo_o <= ir_shift_q[0];
      else if (state_q == ShiftDr) tdo_o <= dr_shift_q[0];
      else                         tdo_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (tap_rst) begin
      gpio_update_valid_o <= 1'b0;
    end else begin
      gpio_update_valid_o <= tck_fall && (state_q == UpdateDr) &&
                             (ir_q == chip_pkg::InstrGpio);
    end
  end

  assign gpio_update_o = dr_shift_q;

endmodule

/* design/gpio_core.sv */
// Chip core with the JTAG TAP and the GPIO register block
// Registers are written through the TAP GPIO data register

`timescale 1ns/100ps

module gpio_core (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic                         jtag_active_i,
  input  logic                         tck_i,
  input  logic                         tms_i,
  input  logic                         tdi_i,
  output logic                         tdo_o,
  input  logic [chip_pkg::NumGpio-1:0] gpio_in_i,
  output logic [chip_pkg::NumGpio-1:0] gpio_out_o,
  output logic [chip_pkg::NumGpio-1:0] gpio_oe_o,
  output logic [chip_pkg::NumGpio-1:0] gpio_invert_o
);

  localparam int N         = chip_pkg::NumGpio;
  localparam int OeLsb     = N;
  localparam int InvLsb    = 2 * N;
  localparam int MirrorIdx = 3 * N;
  localparam int MirBits   = 4;  // MIO 3..0 onto MIO 7..4
  localparam int MirDstLsb = 4;

  logic [N-1:0]                     out_q;
  logic [N-1:0]                     oe_q;
  logic [N-1:0]                     invert_q;
  logic                             mirror_q;
  logic [chip_pkg::GpioDrWidth-1:0] dr_capture;
  logic [chip_pkg::GpioDrWidth-1:0] dr_update;
  logic                             dr_update_valid;

  jtag_tap jtag_tap (
    .clk                 ( clk             ),
    .rst_i               ( rst_i           ),
    .jtag_active_i       ( jtag_active_i   ),
    .tck_i               ( tck_i           ),
    .tms_i               ( tms_i           ),
    .tdi_i               ( tdi_i           ),
    .tdo_o               ( tdo_o           ),
    .gpio_capture_i      ( dr_capture      ),
    .gpio_update_o       ( dr_update       ),
    .gpio_update_valid_o ( dr_update_valid )
  );

  // Live inputs in the out field, register contents elsewhere
  assign dr_capture = {mirror_q, invert_q, oe_q, gpio_in_i};

  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      invert_q <= '0;
      mirror_q <= 1'b0;
    end else if (dr_update_valid) begin
      out_q    <= dr_update[N-1:0];
      oe_q     <= dr_update[OeLsb +: N];
      invert_q <= dr_update[InvLsb +: N];
      mirror_q <= dr_update[MirrorIdx];
    end
  end

  always_comb begin
    gpio_out_o = out_q;
    if (mirror_q) gpio_out_o[MirDstLsb +: MirBits] = gpio_in_i[MirBits-1:0];
  end

  assign gpio_oe_o = oe_q;

  // JTAG pads must never be inverted while the TAP owns them
  always_comb begin
    gpio_invert_o = invert_q;
    if (jtag_active_i) gpio_invert_o[N-1:chip_pkg::NumMio] = '0;
  end

endmodule

/* design/board_top.sv */
// Board level wrapper: pad ring, JTAG overlay mux and chip core
// Pads are modelled as split in/out/oe vectors, MIO in the low bits

`timescale 1ns/100ps

module board_top (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic [chip_pkg::NumPads-1:0] pad_in_i,
  output logic [chip_pkg::NumPads-1:0] pad_out_o,
  output logic [chip_pkg::NumPads-1:0] pad_oe_o
);

  localparam logic [chip_pkg::NumPads-1:0] ConnectMask    = '1;
  localparam logic [chip_pkg::NumPads-1:0] TieOffValues   = '0;
  localparam bit                           JtagEnPolarity = 1'b1;

  logic [chip_pkg::NumPads-1:0] in_padring, out_padring, oe_padring;
  logic [chip_pkg::NumPads-1:0] pad_invert;
  logic [chip_pkg::NumGpio-1:0] in_core, out_core, oe_core;
  logic [chip_pkg::NumGpio-1:0] gpio_invert;
  logic jtag_tck, jtag_tms, jtag_tdi, jtag_tdo;
  logic jtag_active;

  assign pad_invert = {1'b0, gpio_invert};  // Strap pad is never inverted

  pad_ring #(
    .ConnectMask ( ConnectMask )
  ) pad_ring (
    .clk       ( clk         ),
    .rst_i     ( rst_i       ),
    .pad_in_i  ( pad_in_i    ),
    .pad_out_o ( pad_out_o   ),
    .pad_oe_o  ( pad_oe_o    ),
    .in_o      ( in_padring  ),
    .out_i     ( out_padring ),
    .oe_i      ( oe_padring  ),
    .invert_i  ( pad_invert  )
  );

  jtag_overlay_mux #(
    .TieOffValues   ( TieOffValues   ),
    .JtagEnPolarity ( JtagEnPolarity )
  ) jtag_overlay_mux (
    .in_padring_i  ( in_padring  ),
    .out_padring_o ( out_padring ),
    .oe_padring_o  ( oe_padring  ),
    .in_core_o     ( in_core     ),
    .out_core_i    ( out_core    ),
    .oe_core_i     ( oe_core     ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_tdo_i    ( jtag_tdo    ),
    .jtag_active_o ( jtag_active )
  );

  gpio_core gpio_core (
    .clk           ( clk         ),
    .rst_i         ( rst_i       ),
    .jtag_active_i ( jtag_active ),
    .tck_i         ( jtag_tck    ),
    .tms_i         ( jtag_tms    ),
    .tdi_i         ( jtag_tdi    ),
    .tdo_o         ( jtag_tdo    ),
    .gpio_in_i     ( in_core     ),
    .gpio_out_o    ( out_core    ),
    .gpio_oe_o     ( oe_core     ),
    .gpio_invert_o ( gpio_invert )
  );

endmodule

/* tests/board_checker.sv */
// Watches the board pads and the scanned JTAG words and counts mismatches
// Pads compare at the check strobe, words at the word strobe

`timescale 1ns/100ps

module board_checker (
  input  logic                             clk,
  input  logic                             check_i,
  input  logic [chip_pkg::NumPads-1:0]     exp_out_i,
  input  logic [chip_pkg::NumPads-1:0]     exp_oe_i,
  input  logic [chip_pkg::NumPads-1:0]     care_i,      // Pads whose value counts
  input  logic [chip_pkg::NumPads-1:0]     pad_out_i,
  input  logic [chip_pkg::NumPads-1:0]     pad_oe_i,
  input  logic                             word_check_i,
  input  logic [chip_pkg::GpioDrWidth-1:0] exp_word_i,
  input  logic [chip_pkg::GpioDrWidth-1:0] got_word_i,
  output int                               pad_errors_o,
  output int                               word_errors_o
);

  int pad_errors  = 0;
  int word_errors = 0;

  assign pad_errors_o  = pad_errors;
  assign word_errors_o = word_errors;

  // Strobes change on the falling edge, so the rising edge sees settled pads
  always @(posedge clk) begin
    if (check_i && (pad_oe_i !== exp_oe_i ||
                    ((pad_out_i ^ exp_out_i) & care_i) !== '0)) begin
      pad_errors <= pad_errors + 1;
      $display("error at %0d ns: pads out %b oe %b, expected out %b oe %b care %b",
               $time, pad_out_i, pad_oe_i, exp_out_i, exp_oe_i, care_i);
    end
    if (word_check_i && got_word_i !== exp_word_i) begin
      word_errors <= word_errors + 1;
      $display("error at %0d ns: scanned word %h, expected %h",
               $time, got_word_i, exp_word_i);
    end
  end

endmodule

/* tests/tb_board_top.sv */
// Testbench for the board wrapper: drives pads and JTAG, checks pads and scans
// Expected pads and capture words come from reference functions below

`timescale 1ns/100ps

module tb_board_top;

  localparam int Np           = chip_pkg::NumPads;
  localparam int Ng           = chip_pkg::NumGpio;
  localparam int Dw           = chip_pkg::GpioDrWidth;
  localparam int Mio          = chip_pkg::NumMio;
  localparam int Tck          = Mio + chip_pkg::DioTck;
  localparam int Tms          = Mio + chip_pkg::DioTms;
  localparam int Tdi          = Mio + chip_pkg::DioTdi;
  localparam int Tdo          = Mio + chip_pkg::DioTdo;
  localparam int Strap        = Mio + chip_pkg::DioJtagEn;
  localparam int SettleCycles = 16;
  localparam int RunLimit     = 10000;

  logic          clk;
  logic          rst_i;
  logic [Np-1:0] pad_in, pad_out, pad_oe;
  logic [Np-1:0] exp_out, exp_oe, care;
  logic          check, word_check;
  logic [Dw-1:0] exp_word, got_word, gpio_word, next_word, rnd, dout;
  logic [15:0]   lfsr;
  int            pad_errors, word_errors;

  always #10 clk = ~clk;

  board_top dut0 (
    .clk       ( clk     ),
    .rst_i     ( rst_i   ),
    .pad_in_i  ( pad_in  ),
    .pad_out_o ( pad_out ),
    .pad_oe_o  ( pad_oe  )
  );

  board_checker checker0 (
    .clk           ( clk         ),
    .check_i       ( check       ),
    .exp_out_i     ( exp_out     ),
    .exp_oe_i      ( exp_oe      ),
    .care_i        ( care        ),
    .pad_out_i     ( pad_out     ),
    .pad_oe_i      ( pad_oe      ),
    .word_check_i  ( word_check  ),
    .exp_word_i    ( exp_word    ),
    .got_word_i    ( got_word    ),
    .pad_errors_o  ( pad_errors  ),
    .word_errors_o ( word_errors )
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model and random source
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Taps 16 14 13 11
  endfunction

  // Expected {care, oe, out} of every pad for a loaded GPIO word
  function automatic logic [3*Np-1:0] expected_pads(input logic [Dw-1:0] w,
                                                     input logic [Np-1:0] pins,
                                                     input logic jtag_on);
    logic [Ng-1:0] out_v;
    logic [Ng-1:0] inv_v;
    logic [Np-1:0] oe_v;
    logic [Np-1:0] care_v;
    out_v = w[Ng-1:0];
    inv_v = w[3*Ng-1:2*Ng];
    if (w[Dw-1]) out_v[7:4] = pins[3:0] ^ inv_v[3:0];  // Mirror sees inverted inputs
    oe_v = {1'b0, w[2*Ng-1:Ng]};
    if (jtag_on) oe_v[Tdo:Tck] = 4'b1000;  // Only TDO drives
    care_v = oe_v;
    if (jtag_on) care_v[Tdo] = 1'b0;       // TDO value belongs to the TAP
    return {care_v, oe_v, 1'b0, out_v ^ inv_v};
  endfunction

  // Capture while JTAG owns the dedicated pads, which read as tie-offs
  function automatic logic [Dw-1:0] expected_capture(input logic [Dw-1:0] w,
                                                      input logic [Np-1:0] pins);
    logic [Ng-1:0] in_v;
    in_v = pins[Ng-1:0] ^ w[3*Ng-1:2*Ng];
    in_v[Tdo:Tck] = '0;
    return {w[Dw-1:Ng], in_v};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Pad and JTAG driving
  //////////////////////////////////////////////////////////////////////

  task automatic random_word(input int n, output logic [Dw-1:0] w);
    int i;
    w = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  // One TCK period, TDO read just before the rising edge
  task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
    pad_in[Tck] = 1'b0;
    pad_in[Tms] = tms;
    pad_in[Tdi] = tdi;
    repeat (4) @(negedge clk);
    tdo = pad_out[Tdo];
    pad_in[Tck] = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic tap_reset();
    logic tdo;
    repeat (5) tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);  // Run-Test/Idle
  endtask

  // From Run-Test/Idle through a DR or IR scan and back
  task automatic scan(input logic is_ir, input logic [Dw-1:0] din, input int n,
                      output logic [Dw-1:0] got);
    logic tdo;
    int   i;
    got = '0;
    tck_cycle(1'b1, 1'b0, tdo);
    if (is_ir) tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);  // Capture
    tck_cycle(1'b0, 1'b0, tdo);  // Into Shift
    for (i = 0; i < n; i++) begin
      tck_cycle(i == n - 1, din[i], tdo);
      got[i] = tdo;
    end
    tck_cycle(1'b1, 1'b0, tdo);  // Update
    tck_cycle(1'b0, 1'b0, tdo);
  endtask

  // Pads get the settle time, then the checker compares
  task automatic settle_and_check(input logic [3*Np-1:0] exp, input int settle);
    int n;
    {care, exp_oe, exp_out} = exp;
    for (n = 0; n < settle; n++) begin
      @(negedge clk);
    end
    check = 1'b1;
    @(negedge clk);
    check = 1'b0;
  endtask

  task automatic compare_word(input logic [Dw-1:0] e, input logic [Dw-1:0] g);
    exp_word   = e;
    got_word   = g;
    word_check = 1'b1;
    @(negedge clk);
    word_check = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int k;
    clk        = 1'b0;
    rst_i      = 1'b1;
    pad_in     = '0;
    check      = 1'b0;
    word_check = 1'b0;
    {care, exp_oe, exp_out} = '0;
    exp_word   = '0;
    got_word   = '0;
    gpio_word  = '0;
    lfsr       = 16'd31;

    // No pad drives during reset, strap raised halfway
    repeat (8) @(negedge clk);
    pad_in[Strap] = 1'b1;
    repeat (7) @(negedge clk);
    settle_and_check('0, 0);
    rst_i = 1'b0;
    pad_in[Strap] = 1'b0;
    repeat (4) @(negedge clk);
    settle_and_check(expected_pads(gpio_word, pad_in, 1'b0), SettleCycles);

    // IDCODE after a TAP reset
    pad_in[Strap] = 1'b1;
    settle_and_check(expected_pads(gpio_word, pad_in, 1'b1), SettleCycles);
    tap_reset();
    scan(1'b0, '0, 32, dout);
    compare_word(Dw'(chip_pkg::IdCode), dout);

    // Bypass returns TDI one bit late behind the captured zero
    scan(1'b1, Dw'(chip_pkg::InstrBypass), chip_pkg::IrWidth, dout);
    random_word(16, rnd);
    scan(1'b0, rnd, 16, dout);
    compare_word(Dw'({rnd[14:0], 1'b0}), dout);

    // Each GPIO scan captures the previous state and loads a new one
    scan(1'b1, Dw'(chip_pkg::InstrGpio), chip_pkg::IrWidth, dout);
    for (k = 0; k < 4; k++) begin
      random_word(Mio, rnd);
      pad_in[Mio-1:0] = rnd[Mio-1:0];
      random_word(Dw - 1, next_word);  // Mirror off
      scan(1'b0, next_word, Dw, dout);
      compare_word(expected_capture(gpio_word, pad_in), dout);
      gpio_word = next_word;
      settle_and_check(expected_pads(gpio_word, pad_in, 1'b1), SettleCycles);
    end

    // Mirror on, then the dedicated pads return to GPIO
    random_word(Dw - 1, next_word);
    next_word[Dw-1] = 1'b1;
    next_word[2*Ng-1:Ng+4] = '1;  // MIO 7..4 and DIO 3..0 drive
    scan(1'b0, next_word, Dw, dout);
    compare_word(expected_capture(gpio_word, pad_in), dout);
    gpio_word = next_word;
    pad_in[Strap] = 1'b0;
    settle_and_check(expected_pads(gpio_word, pad_in, 1'b0), SettleCycles);
    for (k = 0; k < 6; k++) begin
      random_word(4, rnd);
      pad_in[3:0] = rnd[3:0];
      settle_and_check(expected_pads(gpio_word, pad_in, 1'b0), SettleCycles);
    end

    repeat (4) @(negedge clk);
    $display("errors: pads %0d, words %0d", pad_errors, word_errors);
    if (pad_errors + word_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Whole-run limit
  initial begin
    int c;
    for (c = 0; c < RunLimit; c++) @(posedge clk);
    $display("timeout: simulation did not finish within %0d cycles", RunLimit);
    $display("tests failed");
    $finish;
  end

endmodule

/* flist.f */
design/chip_pkg.sv
design/pad_ring.sv
design/jtag_overlay_mux.sv
design/jtag_tap.sv
design/gpio_core.sv
design/board_top.sv
tests/board_checker.sv
tests/tb_board_top.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_board_top \
  -f flist.f -o tb_board_top > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_board_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "tests failed" sim.log; then
  exit 1
fi
exit 0
